// File: logic/mtd3l_defines.svh
/*
 widths shared by the MTD3L adder pipeline
 the sum carries one extra bit for the final carry
*/
`ifndef MTD3L_DEFINES_SVH
`define MTD3L_DEFINES_SVH

// binary operand width
`define MTD3L_OPERAND_WIDTH 4

// operand width plus carry out
`define MTD3L_SUM_WIDTH (`MTD3L_OPERAND_WIDTH + 1)

`endif

// File: logic/mtd3l_pkg.sv
/*
 dual-rail encoding uses a single all-zero spacer
 DATA is exactly one rail high, both rails high is illegal
*/
`default_nettype none

`include "mtd3l_defines.svh"

package mtd3l_pkg;

  // one dual-rail signal, rail1 high means logic 1
  typedef struct packed {
    logic rail1;
    logic rail0;
  } dual_rail_t;

  // binary words on the clocked side
  typedef logic [`MTD3L_OPERAND_WIDTH-1:0] operand_t;
  typedef logic [`MTD3L_SUM_WIDTH-1:0] sum_t;

  // dual-rail words inside the pipeline
  typedef dual_rail_t [`MTD3L_OPERAND_WIDTH-1:0] dr_operand_t;
  typedef dual_rail_t [`MTD3L_SUM_WIDTH-1:0] dr_sum_t;

  // both adder operands as they pass through the register stage
  typedef struct packed {
    dr_operand_t a;
    dr_operand_t b;
  } dr_operand_pair_t;

  // input interface token states
  typedef enum logic [1:0] {
    feed_idle,
    feed_wait,
    feed_data,
    feed_spacer
  } feed_state_t;

  // output collector phases
  typedef enum logic {
    wait_data,
    wait_spacer
  } collect_state_t;

endpackage

`default_nettype wire

// File: logic/andtree_m.sv
/*
 sleep-gated completion tree with emulated hysteresis
 one clock of latency, state updates on the rising clk edge
 inputs that are neither all high nor all low hold the output
*/
`timescale 1ns/1ns
`default_nettype none

module andtree_m #(
  parameter int WIDTH = 4
) (
  input  wire logic [WIDTH-1:0] a,
  input  wire logic             sleep,
  input  wire logic             clk,
  input  wire logic             rst,
  output logic                  all_data
);

  logic all_high;
  logic all_low;

  // threshold-gate set and reset conditions
  assign all_high = &a;
  assign all_low  = ~|a;

  always_ff @(posedge clk) begin
    if (rst) begin
      all_data <= 1'b0;
    end else if (sleep || all_low) begin
      // sleep forces the tree back to its null state
      all_data <= 1'b0;
    end else if (all_high) begin
      all_data <= 1'b1;
    end
    // partial inputs keep the previous value
  end

endmodule

`default_nettype wire

// File: logic/completion_mtd3l.sv
/*
 MTD3L completion for the register inputs of one stage
 RESET_KO high resets to request for data, low to request for spacer
 ko settles two clocks after the last input change
 ps and not_ps select the spacer polarity used while sleeping
*/
`timescale 1ns/1ns
`default_nettype none

module completion_mtd3l import mtd3l_pkg::*; #(
  parameter int WIDTH    = 4,
  parameter bit RESET_KO = 1'b1
) (
  input  wire logic                   clk,
  input  wire logic                   rst,
  input  wire dual_rail_t [WIDTH-1:0] a,
  input  wire logic                   ki,
  input  wire logic                   sleep,
  input  wire logic                   ps,
  input  wire logic                   not_ps,
  output logic                        ko,
  output logic                        s0,
  output logic                        ns1
);

  logic [WIDTH-1:0] bit_data;
  logic             comp_signal;
  logic             not_ko;

  // per-bit DATA detect, one rail high
  always_comb begin
    for (int i = 0; i < WIDTH; i++) begin
      bit_data[i] = a[i].rail1 ^ a[i].rail0;
    end
  end

  // collapse all bits, first clocked level
  andtree_m #(
    .WIDTH(WIDTH)
  ) u_tree (
    .a       (bit_data),
    .sleep   (sleep),
    .clk     (clk),
    .rst     (rst),
    .all_data(comp_signal)
  );

  // C-element with the next stage request, second clocked level
  always_ff @(posedge clk) begin
    if (rst) begin
      not_ko <= ~RESET_KO;
    end else if (comp_signal && ki) begin
      not_ko <= 1'b1;
    end else if (!comp_signal && !ki) begin
      not_ko <= 1'b0;
    end
  end

  assign ko = ~not_ko;

  // data held: s0 low, ns1 high
  // otherwise s0 is not(not_ps) and ns1 is ps
  assign s0  = ~(not_ko | not_ps);
  assign ns1 = not_ko | ps;

endmodule

`default_nettype wire

// File: logic/register_mtd3l.sv
/*
 token-holding MTD3L register for both adder operands
 evaluates only with s0 low and ns1 high, any other pair sleeps it
 a bit latches DATA once and keeps it until sleep
*/
`timescale 1ns/1ns
`default_nettype none

`include "mtd3l_defines.svh"

module register_mtd3l import mtd3l_pkg::*; (
  input  wire logic             clk,
  input  wire logic             rst,
  input  wire dr_operand_pair_t d,
  input  wire logic             s0,
  input  wire logic             ns1,
  output dr_operand_pair_t      q
);

  logic sleep_mode;

  // data held means s0 low and ns1 high
  assign sleep_mode = s0 | ~ns1;

  always_ff @(posedge clk) begin
    if (rst) begin
      q <= '0;
    end else if (sleep_mode) begin
      // force spacer on every rail
      q <= '0;
    end else begin
      for (int i = 0; i < `MTD3L_OPERAND_WIDTH; i++) begin
        // capture only from spacer, so DATA stays while d returns to spacer
        if (!(q.a[i].rail1 || q.a[i].rail0)) begin
          q.a[i] <= d.a[i];
        end
        if (!(q.b[i].rail1 || q.b[i].rail0)) begin
          q.b[i] <= d.b[i];
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/sync_to_mtd3l.sv
/*
 clocked to MTD3L input interface, one token at a time
 a token is accepted only while in_ready is high
 DATA is driven while ki is high, spacer until ki returns high
 sleep is high whenever the rails carry spacer
*/
`timescale 1ns/1ns
`default_nettype none

`include "mtd3l_defines.svh"

module sync_to_mtd3l import mtd3l_pkg::*; (
  input  wire logic     clk,
  input  wire logic     rst,
  input  wire logic     in_valid,
  input  wire operand_t op_a,
  input  wire operand_t op_b,
  input  wire logic     ki,
  output logic          in_ready,
  output dr_operand_t   a_dr,
  output dr_operand_t   b_dr,
  output logic          sleep
);

  feed_state_t state;
  operand_t    op_a_q;
  operand_t    op_b_q;
  logic        send_data;

  assign in_ready  = (state == feed_idle);
  assign send_data = (state == feed_data);
  // input completion, sleep low means DATA on the rails
  assign sleep     = ~send_data;

  // token handshake against the stage request
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= feed_idle;
    end else begin
      case (state)
        feed_idle: begin
          if (in_valid) begin
            state <= ki ? feed_data : feed_wait;
          end
        end
        feed_wait: begin
          // operands held until the stage asks for data
          if (ki) begin
            state <= feed_data;
          end
        end
        feed_data: begin
          // ko low, DATA has been taken
          if (!ki) begin
            state <= feed_spacer;
          end
        end
        default: begin
          // spacer seen downstream, free for the next token
          if (ki) begin
            state <= feed_idle;
          end
        end
      endcase
    end
  end

  // operand capture on acceptance
  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      op_a_q <= op_a;
      op_b_q <= op_b;
    end
  end

  // binary to dual-rail, all rails low outside the data phase
  always_comb begin
    for (int i = 0; i < `MTD3L_OPERAND_WIDTH; i++) begin
      a_dr[i].rail1 = send_data & op_a_q[i];
      a_dr[i].rail0 = send_data & ~op_a_q[i];
      b_dr[i].rail1 = send_data & op_b_q[i];
      b_dr[i].rail0 = send_data & ~op_b_q[i];
    end
  end

endmodule

`default_nettype wire

// File: logic/dual_rail_adder.sv
/*
 dual-rail ripple adder from emulated threshold gates
 each bit is one clocked level, so latency follows the carry chain
 a bit evaluates on all-DATA inputs and resets on all-spacer inputs
*/
`timescale 1ns/1ns
`default_nettype none

`include "mtd3l_defines.svh"

module dual_rail_adder import mtd3l_pkg::*; (
  input  wire logic        clk,
  input  wire logic        rst,
  input  wire dr_operand_t a_dr,
  input  wire dr_operand_t b_dr,
  output dr_sum_t          sum_dr
);

  localparam int W = `MTD3L_OPERAND_WIDTH;

  dual_rail_t [W-1:0] sum_q;
  dual_rail_t [W-1:0] carry_q;
  dual_rail_t [W-1:0] carry_in;
  logic [W-1:0]       all_data;
  logic [W-1:0]       all_spacer;
  logic [W-1:0]       s_bin;
  logic [W-1:0]       c_bin;

  always_comb begin
    // bit 0 carry in is a DATA zero that follows a_dr[0]
    carry_in[0].rail1 = 1'b0;
    carry_in[0].rail0 = a_dr[0].rail1 | a_dr[0].rail0;
    for (int i = 1; i < W; i++) begin
      carry_in[i] = carry_q[i-1];
    end
    for (int i = 0; i < W; i++) begin
      all_data[i] = (a_dr[i].rail1 | a_dr[i].rail0) &
                    (b_dr[i].rail1 | b_dr[i].rail0) &
                    (carry_in[i].rail1 | carry_in[i].rail0);
      all_spacer[i] = ~(a_dr[i].rail1 | a_dr[i].rail0 |
                        b_dr[i].rail1 | b_dr[i].rail0 |
                        carry_in[i].rail1 | carry_in[i].rail0);
      // full adder on the rail1 values, valid only under all_data
      s_bin[i] = a_dr[i].rail1 ^ b_dr[i].rail1 ^ carry_in[i].rail1;
      c_bin[i] = (a_dr[i].rail1 & b_dr[i].rail1) |
                 (carry_in[i].rail1 & (a_dr[i].rail1 ^ b_dr[i].rail1));
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      sum_q   <= '0;
      carry_q <= '0;
    end else begin
      for (int i = 0; i < W; i++) begin
        if (all_data[i]) begin
          sum_q[i]   <= '{rail1: s_bin[i], rail0: ~s_bin[i]};
          carry_q[i] <= '{rail1: c_bin[i], rail0: ~c_bin[i]};
        end else if (all_spacer[i]) begin
          sum_q[i]   <= '0;
          carry_q[i] <= '0;
        end
        // mixed inputs hold the gate
      end
    end
  end

  // top bit is the final carry
  assign sum_dr = {carry_q[W-1], sum_q};

endmodule

`default_nettype wire

// File: logic/mtd3l_to_sync.sv
/*
 MTD3L to clocked output collector, always ready
 out_valid pulses one clock after full DATA is detected
 ko stays low until the whole sum has returned to spacer
*/
`timescale 1ns/1ns
`default_nettype none

`include "mtd3l_defines.svh"

module mtd3l_to_sync import mtd3l_pkg::*; (
  input  wire logic    clk,
  input  wire logic    rst,
  input  wire dr_sum_t sum_dr,
  output logic         ko,
  output logic         out_valid,
  output sum_t         sum
);

  collect_state_t              state;
  logic [`MTD3L_SUM_WIDTH-1:0] bit_data;
  logic [`MTD3L_SUM_WIDTH-1:0] bit_spacer;
  logic                        all_data_q;
  logic                        all_spacer_q;

  always_comb begin
    for (int i = 0; i < `MTD3L_SUM_WIDTH; i++) begin
      bit_data[i]   = sum_dr[i].rail1 ^ sum_dr[i].rail0;
      bit_spacer[i] = ~(sum_dr[i].rail1 | sum_dr[i].rail0);
    end
  end

  // completion level, one clock
  always_ff @(posedge clk) begin
    if (rst) begin
      all_data_q   <= 1'b0;
      all_spacer_q <= 1'b1;
    end else begin
      all_data_q   <= &bit_data;
      all_spacer_q <= &bit_spacer;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= wait_data;
      ko        <= 1'b1;
      out_valid <= 1'b0;
    end else begin
      out_valid <= 1'b0;
      case (state)
        wait_data: begin
          if (all_data_q) begin
            out_valid <= 1'b1;
            ko        <= 1'b0;
            state     <= wait_spacer;
          end
        end
        default: begin
          // request the next token once spacer is complete
          if (all_spacer_q) begin
            ko    <= 1'b1;
            state <= wait_data;
          end
        end
      endcase
    end
  end

  // decode on the same edge, rails still hold DATA here
  always_ff @(posedge clk) begin
    if (state == wait_data && all_data_q) begin
      for (int i = 0; i < `MTD3L_SUM_WIDTH; i++) begin
        sum[i] <= sum_dr[i].rail1;
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/mtd3l_adder_top.sv
/*
 clocked 4-bit adder through a one-register MTD3L pipeline
 result latency depends on the data and the handshake
 results leave in acceptance order, no output back-pressure
*/
`timescale 1ns/1ns
`default_nettype none

`include "mtd3l_defines.svh"

module mtd3l_adder_top import mtd3l_pkg::*; (
  input  wire logic     clk,
  input  wire logic     rst,
  input  wire logic     in_valid,
  input  wire operand_t op_a,
  input  wire operand_t op_b,
  output logic          in_ready,
  output logic          out_valid,
  output sum_t          sum
);

  dr_operand_t      a_dr;
  dr_operand_t      b_dr;
  dr_operand_pair_t reg_d;
  dr_operand_pair_t reg_q;
  dr_sum_t          sum_dr;
  logic             feed_sleep;
  logic             stage_ko;
  logic             stage_s0;
  logic             stage_ns1;
  logic             coll_ko;

  assign reg_d = {a_dr, b_dr};

  sync_to_mtd3l u_sync_in (
    .clk     (clk),
    .rst     (rst),
    .in_valid(in_valid),
    .op_a    (op_a),
    .op_b    (op_b),
    .ki      (stage_ko),
    .in_ready(in_ready),
    .a_dr    (a_dr),
    .b_dr    (b_dr),
    .sleep   (feed_sleep)
  );

  // watches the register inputs, held in request for data after reset
  // only the zero spacer exists, so the previous spacer is always ps low
  completion_mtd3l #(
    .WIDTH   (2 * `MTD3L_OPERAND_WIDTH),
    .RESET_KO(1'b1)
  ) u_comp (
    .clk   (clk),
    .rst   (rst),
    .a     (reg_d),
    .ki    (coll_ko),
    .sleep (feed_sleep),
    .ps    (1'b0),
    .not_ps(1'b1),
    .ko    (stage_ko),
    .s0    (stage_s0),
    .ns1   (stage_ns1)
  );

  register_mtd3l u_reg (
    .clk(clk),
    .rst(rst),
    .d  (reg_d),
    .s0 (stage_s0),
    .ns1(stage_ns1),
    .q  (reg_q)
  );

  dual_rail_adder u_adder (
    .clk   (clk),
    .rst   (rst),
    .a_dr  (reg_q.a),
    .b_dr  (reg_q.b),
    .sum_dr(sum_dr)
  );

  mtd3l_to_sync u_sync_out (
    .clk      (clk),
    .rst      (rst),
    .sum_dr   (sum_dr),
    .ko       (coll_ko),
    .out_valid(out_valid),
    .sum      (sum)
  );

endmodule

`default_nettype wire

// File: tests/tb_mtd3l_adder.sv
/*
 testbench for the clocked MTD3L adder pipeline
 inputs change on the falling clk edge, outputs are sampled there too
 expected sums sit in a queue and are popped on every out_valid pulse
 every wait is bounded and the first error stops the run
*/
`timescale 1ns/1ns
`default_nettype none

module tb_mtd3l_adder import mtd3l_pkg::*; ();

  localparam int READY_TIMEOUT = 100;
  localparam int DRAIN_TIMEOUT = 300;
  localparam int RANDOM_PAIRS  = 200;
  localparam int NUM_VECTORS   = 14;
  localparam int QUIET_CYCLES  = 40;

  // one table row, expected sum worked out by hand as a plus b
  typedef struct packed {
    operand_t a;
    operand_t b;
    sum_t     sum;
  } vector_t;

  logic     clk;
  logic     rst;
  logic     in_valid;
  operand_t op_a;
  operand_t op_b;
  logic     in_ready;
  logic     out_valid;
  sum_t     sum;

  vector_t  vectors [NUM_VECTORS];
  sum_t     expected_q [$];
  int       seed;

  mtd3l_adder_top u_dut (
    .clk      (clk),
    .rst      (rst),
    .in_valid (in_valid),
    .op_a     (op_a),
    .op_b     (op_b),
    .in_ready (in_ready),
    .out_valid(out_valid),
    .sum      (sum)
  );

  // 4 ns clock
  initial begin
    clk = 1'b0;
    forever begin
      #2 clk = ~clk;
    end
  end

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped on the first failure");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      stop_with_failure($sformatf("ERROR at %0t ns: %s is %0d, expected %0d",
                                  $time, name, actual, expected));
    end
  endtask

  // optionally holds in_valid high with decoy operands while in_ready is low
  task automatic wait_for_ready(input bit hold_valid, input operand_t a, input operand_t b);
    int cycles;
    cycles = 0;
    while (!in_ready) begin
      in_valid = hold_valid;
      op_a     = ~a;
      op_b     = ~b;
      @(negedge clk);
      cycles++;
      if (cycles > READY_TIMEOUT) begin
        stop_with_failure("timeout waiting for in_ready to go high");
      end
    end
  endtask

  // in_ready seen high at this falling edge, so the next rising edge accepts
  task automatic send_pair(input operand_t a, input operand_t b, input sum_t expected,
                           input bit hold_valid);
    wait_for_ready(hold_valid, a, b);
    in_valid = 1'b1;
    op_a     = a;
    op_b     = b;
    expected_q.push_back(expected);
    @(negedge clk);
    in_valid = 1'b0;
  endtask

  // every accepted input leaves and no extra result follows
  task automatic wait_for_drain();
    int cycles;
    cycles = 0;
    while (expected_q.size() != 0) begin
      @(negedge clk);
      cycles++;
      if (cycles > DRAIN_TIMEOUT) begin
        stop_with_failure("timeout waiting for out_valid on an accepted input");
      end
    end
    // a late duplicate pulse lands here with nothing pending
    repeat (QUIET_CYCLES) @(negedge clk);
  endtask

  // result monitor, an out_valid with nothing pending is a duplicate or a ghost
  always @(negedge clk) begin
    if (!rst && out_valid) begin
      if (expected_q.size() == 0) begin
        stop_with_failure("out_valid pulsed with no accepted input pending");
      end else begin
        check_value("sum", sum, expected_q.pop_front());
      end
    end
  end

  initial begin
    logic [31:0] rnd;
    operand_t    ra;
    operand_t    rb;

    rst            = 1'b1;
    in_valid       = 1'b0;
    op_a           = '0;
    op_b           = '0;
    seed           = 32'h4ca1;

    // corner cases first, then carries of every length
    vectors[0]  = '{4'd0, 4'd0, 5'd0};
    vectors[1]  = '{4'd15, 4'd15, 5'd30};
    vectors[2]  = '{4'd15, 4'd1, 5'd16};
    vectors[3]  = '{4'd1, 4'd15, 5'd16};
    vectors[4]  = '{4'd7, 4'd8, 5'd15};
    vectors[5]  = '{4'd8, 4'd8, 5'd16};
    vectors[6]  = '{4'd5, 4'd10, 5'd15};
    vectors[7]  = '{4'd3, 4'd4, 5'd7};
    vectors[8]  = '{4'd9, 4'd6, 5'd15};
    vectors[9]  = '{4'd12, 4'd13, 5'd25};
    vectors[10] = '{4'd1, 4'd1, 5'd2};
    vectors[11] = '{4'd0, 4'd15, 5'd15};
    vectors[12] = '{4'd7, 4'd7, 5'd14};
    vectors[13] = '{4'd11, 4'd3, 5'd14};

    repeat (3) @(negedge clk);
    rst = 1'b0;

    // state after reset
    wait_for_ready(1'b0, '0, '0);
    check_value("out_valid", out_valid, 0);

    // one token at a time
    for (int i = 0; i < NUM_VECTORS; i++) begin
      send_pair(vectors[i].a, vectors[i].b, vectors[i].sum, 1'b0);
      wait_for_drain();
    end

    // in_valid held high with decoys while in_ready is low
    for (int i = 0; i < NUM_VECTORS; i++) begin
      send_pair(vectors[i].a, vectors[i].b, vectors[i].sum, 1'b1);
    end
    wait_for_drain();

    // back to back, two tokens in flight
    for (int i = NUM_VECTORS - 1; i >= 0; i--) begin
      send_pair(vectors[i].a, vectors[i].b, vectors[i].sum, 1'b0);
    end
    wait_for_drain();

    // random pairs, decoy mode picked by a spare random bit
    for (int i = 0; i < RANDOM_PAIRS; i++) begin
      rnd = $random(seed);
      ra  = rnd[3:0];
      rb  = rnd[7:4];
      send_pair(ra, rb, {1'b0, ra} + {1'b0, rb}, rnd[8]);
    end
    wait_for_drain();

    // reset two cycles after acceptance, well before the result can leave
    send_pair(4'd9, 4'd7, 5'd16, 1'b0);
    @(negedge clk);
    rst = 1'b1;
    expected_q.delete();
    repeat (3) @(negedge clk);
    rst = 1'b0;

    // the monitor flags any out_valid here
    repeat (QUIET_CYCLES) @(negedge clk);
    wait_for_ready(1'b0, '0, '0);
    send_pair(4'd14, 4'd3, 5'd17, 1'b0);
    wait_for_drain();

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
+incdir+logic
logic/mtd3l_pkg.sv
logic/andtree_m.sv
logic/completion_mtd3l.sv
logic/register_mtd3l.sv
logic/sync_to_mtd3l.sv
logic/dual_rail_adder.sv
logic/mtd3l_to_sync.sv
logic/mtd3l_adder_top.sv
tests/tb_mtd3l_adder.sv

// File: Bender.yml
package:
  name: mtd3l_adder

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/mtd3l_pkg.sv
      - logic/andtree_m.sv
      - logic/completion_mtd3l.sv
      - logic/register_mtd3l.sv
      - logic/sync_to_mtd3l.sv
      - logic/dual_rail_adder.sv
      - logic/mtd3l_to_sync.sv
      - logic/mtd3l_adder_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - tests/tb_mtd3l_adder.sv
